// File: src/icache_defs.svh
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// ------------------------------------------------------------
// cache geometry
// ------------------------------------------------------------

// virtual and physical address width
`define ICACHE_ADDR_SIZE   40
// page index bits carried by each fetch request
`define ICACHE_IDX_BITS    12
`define ICACHE_LINE_BYTES  64
`define ICACHE_SETS        16
`define ICACHE_WAYS        4

// ------------------------------------------------------------
// fetch side
// ------------------------------------------------------------

`define ICACHE_FETCH_BITS  128   // one fetch block per response

`endif

// File: src/icache_pkg.sv
`include "icache_defs.svh"

package icache_pkg;

    localparam int unsigned OFFSET_BITS = $clog2(`ICACHE_LINE_BYTES);  // byte within line
    localparam int unsigned SET_BITS    = $clog2(`ICACHE_SETS);
    localparam int unsigned WAY_BITS    = $clog2(`ICACHE_WAYS);
    localparam int unsigned FETCH_SEL_BITS =
        $clog2(`ICACHE_LINE_BYTES * 8 / `ICACHE_FETCH_BITS);
    localparam int unsigned PPN_BITS    = `ICACHE_ADDR_SIZE - SET_BITS - OFFSET_BITS;

    // request side
    typedef logic [`ICACHE_IDX_BITS-1:0]                    idx_t;
    typedef logic [`ICACHE_ADDR_SIZE-`ICACHE_IDX_BITS-1:0]  vpn_t;
    typedef logic [`ICACHE_ADDR_SIZE-1:0]                   vaddr_t;

    // ppn doubles as the stored tag
    typedef logic [PPN_BITS-1:0]                            ppn_t;
    typedef logic [`ICACHE_ADDR_SIZE-1:0]                   paddr_t;

    // array organisation
    typedef logic [SET_BITS-1:0]                            set_t;
    typedef logic [WAY_BITS-1:0]                            way_t;
    typedef logic [`ICACHE_WAYS-1:0]                        way_vec_t;

    typedef logic [`ICACHE_LINE_BYTES*8-1:0]                line_t;
    typedef logic [`ICACHE_FETCH_BITS-1:0]                  fetch_t;
    typedef logic [FETCH_SEL_BITS-1:0]                      fetch_sel_t;

endpackage

// File: src/icache_way_ram.sv
`timescale 1ns/1ns

`include "icache_defs.svh"

module icache_way_ram #(
    parameter type payload_t = logic
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             rd_en_i,
    input  logic             wr_en_i,
    input  icache_pkg::set_t set_i,
    input  payload_t         wdata_i,
    output payload_t         rdata_o
);

    payload_t mem_q [`ICACHE_SETS];

    // one entry per set
    always_ff @(posedge clk_i) begin
        if (wr_en_i) mem_q[set_i] <= wdata_i;
    end

    // registered read port holds its value between reads
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rdata_o <= '0;
        end else if (rd_en_i) begin
            rdata_o <= mem_q[set_i];
        end
    end

endmodule

// File: src/icache_req_stage.sv
`timescale 1ns/1ns

module icache_req_stage (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                ireq_valid_i,
    input  icache_pkg::idx_t    ireq_idx_i,
    input  icache_pkg::vpn_t    ireq_vpn_i,
    input  logic                accept_i,       // request taken this cycle
    input  logic                retranslate_i,  // ask the MMU again with held vpn
    input  logic                tresp_miss_i,
    input  icache_pkg::ppn_t    tresp_ppn_i,
    input  logic                tresp_xcpt_i,
    output logic                treq_valid_o,
    output icache_pkg::vpn_t    treq_vpn_o,
    output icache_pkg::idx_t    idx_o,
    output icache_pkg::vaddr_t  vaddr_o,
    output icache_pkg::ppn_t    ppn_o,
    output logic                mmu_miss_o,
    output logic                mmu_xcpt_o
);
    import icache_pkg::*;

    idx_t idx_q;
    vpn_t vpn_q;

    // held address stays put until the next accepted request
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            idx_q <= '0;
            vpn_q <= '0;
        end else if (accept_i) begin
            idx_q <= ireq_idx_i;
            vpn_q <= ireq_vpn_i;
        end
    end

    // retranslation wins over a new vpn
    assign treq_valid_o = accept_i || retranslate_i;
    assign treq_vpn_o   = (ireq_valid_i && !retranslate_i) ? ireq_vpn_i : vpn_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mmu_miss_o <= 1'b0;
            mmu_xcpt_o <= 1'b0;
        end else if (treq_valid_o) begin
            mmu_miss_o <= tresp_miss_i;
            mmu_xcpt_o <= tresp_xcpt_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (treq_valid_o) ppn_o <= tresp_ppn_i;  // kept for the fill tag
    end

    assign idx_o   = idx_q;
    assign vaddr_o = {vpn_q, idx_q};

endmodule

// File: src/icache_lookup.sv
`timescale 1ns/1ns

`include "icache_defs.svh"

module icache_lookup (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    input  logic                                rd_en_i,
    input  icache_pkg::set_t                    rd_set_i,
    input  logic                                wr_en_i,
    input  icache_pkg::set_t                    wr_set_i,
    input  icache_pkg::ppn_t                    wr_tag_i,
    input  icache_pkg::line_t                   wr_line_i,
    input  logic                                flush_i,
    output icache_pkg::ppn_t  [`ICACHE_WAYS-1:0] tags_o,
    output icache_pkg::line_t [`ICACHE_WAYS-1:0] lines_o,
    output icache_pkg::way_vec_t                valid_o
);
    import icache_pkg::*;

    way_vec_t valid_q [`ICACHE_SETS];
    way_t     rr_q;       // round-robin victim once a set is full
    way_t     victim;
    way_vec_t way_we;
    set_t     ram_set;

    // lowest free way first, else the shared pointer
    always_comb begin
        victim = rr_q;
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[wr_set_i][w]) victim = way_t'(w);
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '{default: '0};
            rr_q    <= '0;
        end else if (flush_i) begin
            valid_q <= '{default: '0};
            rr_q    <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_set_i][victim] <= 1'b1;
            if (&valid_q[wr_set_i]) rr_q <= rr_q + 1'b1;  // eviction
        end
    end

    // valid bits read alongside the arrays
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) valid_o <= '0;
        else if (rd_en_i) valid_o <= valid_q[rd_set_i];
    end

    assign way_we  = wr_en_i ? way_vec_t'(1 << victim) : '0;
    assign ram_set = wr_en_i ? wr_set_i : rd_set_i;  // writes never overlap reads

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_way_ram #(.payload_t(ppn_t)) u_tag (
            .clk_i(clk_i), .rstn_i(rstn_i), .rd_en_i(rd_en_i), .wr_en_i(way_we[w]),
            .set_i(ram_set), .wdata_i(wr_tag_i), .rdata_o(tags_o[w])
        );
        icache_way_ram #(.payload_t(line_t)) u_line (
            .clk_i(clk_i), .rstn_i(rstn_i), .rd_en_i(rd_en_i), .wr_en_i(way_we[w]),
            .set_i(ram_set), .wdata_i(wr_line_i), .rdata_o(lines_o[w])
        );
    end

endmodule

// File: src/icache_hit_check.sv
`timescale 1ns/1ns

`include "icache_defs.svh"

module icache_hit_check (
    input  icache_pkg::ppn_t  [`ICACHE_WAYS-1:0] tags_i,
    input  icache_pkg::line_t [`ICACHE_WAYS-1:0] lines_i,
    input  icache_pkg::way_vec_t                valid_i,
    input  icache_pkg::ppn_t                    ppn_i,    // registered translation
    input  icache_pkg::fetch_sel_t              sel_i,
    output logic                                hit_o,
    output icache_pkg::fetch_t                  data_o
);
    import icache_pkg::*;

    way_vec_t hit_vec;
    line_t    hit_line;

    // ------------------------------------------------------------
    // tag compare
    // ------------------------------------------------------------
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit_vec[w] = valid_i[w] && (tags_i[w] == ppn_i);  // one way at most
            if (hit_vec[w]) hit_line = lines_i[w];
        end
    end

    assign hit_o = |hit_vec;

    // block 0 sits in the low bits of the line
    assign data_o = hit_line[sel_i * `ICACHE_FETCH_BITS +: `ICACHE_FETCH_BITS];

endmodule

// File: src/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic ireq_valid_i,
    input  logic flush_i,
    input  logic hit_i,
    input  logic mmu_miss_i,
    input  logic mmu_xcpt_i,
    input  logic ifill_resp_valid_i,
    output logic ready_o,
    output logic accept_o,
    output logic retranslate_o,
    output logic rd_en_o,             // replay read
    output logic wr_en_o,             // line write from fill
    output logic flush_o,
    output logic resp_valid_o,
    output logic ifill_req_valid_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_TWAIT,    // waiting for the MMU miss to clear
        ST_FILL,
        ST_REPLAY
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   flush_q;
    logic   check;
    logic   respond;

    // tags and translation are both valid to look at in these states
    assign check   = (state_q == ST_LOOKUP) || (state_q == ST_TWAIT);
    assign respond = check && !mmu_miss_i && (mmu_xcpt_i || hit_i);

    assign retranslate_o     = check && mmu_miss_i;
    assign ifill_req_valid_o = check && !mmu_miss_i && !mmu_xcpt_i && !hit_i;
    assign resp_valid_o      = respond;
    assign ready_o  = !flush_q && ((state_q == ST_IDLE) || respond);
    assign accept_o = ireq_valid_i && ready_o;
    assign wr_en_o  = (state_q == ST_FILL) && ifill_resp_valid_i;
    assign rd_en_o  = (state_q == ST_REPLAY);
    assign flush_o  = flush_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (accept_o) state_d = ST_LOOKUP;
            ST_LOOKUP, ST_TWAIT: begin
                if (mmu_miss_i) state_d = ST_TWAIT;
                else if (respond) state_d = accept_o ? ST_LOOKUP : ST_IDLE;
                else state_d = ST_FILL;  // tag miss sends one fill request
            end
            ST_FILL: if (ifill_resp_valid_i) state_d = ST_REPLAY;
            ST_REPLAY: state_d = ST_LOOKUP;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
            flush_q <= 1'b0;
        end else begin
            state_q <= state_d;
            flush_q <= flush_i && ready_o;  // only taken while ready
        end
    end

endmodule

// File: src/icache_top.sv
`timescale 1ns/1ns

`include "icache_defs.svh"

module icache_top (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                flush_i,
    // fetch side
    input  logic                ireq_valid_i,
    input  icache_pkg::idx_t    ireq_idx_i,
    input  icache_pkg::vpn_t    ireq_vpn_i,
    output logic                resp_ready_o,
    output logic                resp_valid_o,
    output icache_pkg::fetch_t  resp_data_o,
    output icache_pkg::vaddr_t  resp_vaddr_o,
    output logic                resp_xcpt_o,
    // MMU
    output logic                treq_valid_o,
    output icache_pkg::vpn_t    treq_vpn_o,
    input  logic                tresp_miss_i,
    input  icache_pkg::ppn_t    tresp_ppn_i,
    input  logic                tresp_xcpt_i,
    // line fill
    output logic                ifill_req_valid_o,
    output icache_pkg::paddr_t  ifill_req_paddr_o,
    input  logic                ifill_resp_valid_i,
    input  icache_pkg::line_t   ifill_resp_data_i
);
    import icache_pkg::*;

    idx_t idx_q;
    ppn_t ppn;
    logic mmu_miss, mmu_xcpt, hit;
    logic accept, retranslate, replay_rd, fill_wr, flush_en;
    set_t rd_set;
    ppn_t  [`ICACHE_WAYS-1:0] tags;
    line_t [`ICACHE_WAYS-1:0] lines;
    way_vec_t valid;

    // ------------------------------------------------------------
    // address routing
    // ------------------------------------------------------------
    assign rd_set = replay_rd ? idx_q[OFFSET_BITS +: SET_BITS]
                              : ireq_idx_i[OFFSET_BITS +: SET_BITS];
    assign ifill_req_paddr_o = {ppn, idx_q[OFFSET_BITS +: SET_BITS], {OFFSET_BITS{1'b0}}};
    assign resp_xcpt_o = resp_valid_o && mmu_xcpt;

    icache_req_stage u_req (
        .clk_i(clk_i), .rstn_i(rstn_i), .ireq_valid_i(ireq_valid_i),
        .ireq_idx_i(ireq_idx_i), .ireq_vpn_i(ireq_vpn_i), .accept_i(accept),
        .retranslate_i(retranslate), .tresp_miss_i(tresp_miss_i),
        .tresp_ppn_i(tresp_ppn_i), .tresp_xcpt_i(tresp_xcpt_i),
        .treq_valid_o(treq_valid_o), .treq_vpn_o(treq_vpn_o), .idx_o(idx_q),
        .vaddr_o(resp_vaddr_o), .ppn_o(ppn), .mmu_miss_o(mmu_miss), .mmu_xcpt_o(mmu_xcpt)
    );

    icache_lookup u_lookup (
        .clk_i(clk_i), .rstn_i(rstn_i), .rd_en_i(accept || replay_rd), .rd_set_i(rd_set),
        .wr_en_i(fill_wr), .wr_set_i(idx_q[OFFSET_BITS +: SET_BITS]), .wr_tag_i(ppn),
        .wr_line_i(ifill_resp_data_i), .flush_i(flush_en),
        .tags_o(tags), .lines_o(lines), .valid_o(valid)
    );

    icache_hit_check u_hit (
        .tags_i(tags), .lines_i(lines), .valid_i(valid), .ppn_i(ppn),
        .sel_i(idx_q[OFFSET_BITS-1 -: FETCH_SEL_BITS]), .hit_o(hit), .data_o(resp_data_o)
    );

    icache_ctrl u_ctrl (
        .clk_i(clk_i), .rstn_i(rstn_i), .ireq_valid_i(ireq_valid_i), .flush_i(flush_i),
        .hit_i(hit), .mmu_miss_i(mmu_miss), .mmu_xcpt_i(mmu_xcpt),
        .ifill_resp_valid_i(ifill_resp_valid_i), .ready_o(resp_ready_o),
        .accept_o(accept), .retranslate_o(retranslate), .rd_en_o(replay_rd),
        .wr_en_o(fill_wr), .flush_o(flush_en), .resp_valid_o(resp_valid_o),
        .ifill_req_valid_o(ifill_req_valid_o)
    );

endmodule

// File: sim/icache_properties.sv
`timescale 1ns/1ns

module icache_properties (
    input logic clk_i,
    input logic rstn_i,
    input logic resp_valid_o,
    input logic resp_ready_o,
    input logic ifill_req_valid_o,
    input logic ifill_resp_valid_i
);

    // a fill request and a response never share a cycle
    a_resp_vs_fill: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(resp_valid_o && ifill_req_valid_o))
        else $error("response and fill request in the same cycle");

    // input side stays blocked for the whole fill
    a_blocked_in_fill: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ifill_req_valid_o |-> !resp_ready_o until resp_valid_o)
        else $error("ready raised during an outstanding fill");

    a_one_fill: assert property (@(posedge clk_i) disable iff (!rstn_i)
        ifill_req_valid_o |=> !ifill_req_valid_o until ifill_resp_valid_i)
        else $error("second fill request before the fill answer");

endmodule

bind icache_top icache_properties u_props (.*);

// File: sim/icache_tb.sv
`timescale 1ns/1ns

`include "icache_defs.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int unsigned TIMEOUT  = 5000;
    localparam ppn_t        PPN_OFS  = 30'h0123_4000;  // mmu model adds this to the vpn
    localparam vpn_t        XCPT_VPN = 28'h0dea_d00;

    logic clk_i, rstn_i, flush_i, ireq_valid_i;
    idx_t ireq_idx_i;
    vpn_t ireq_vpn_i;
    logic resp_ready_o, resp_valid_o, resp_xcpt_o;
    fetch_t resp_data_o;
    vaddr_t resp_vaddr_o;
    logic treq_valid_o, tresp_miss_i, tresp_xcpt_i;
    vpn_t treq_vpn_o;
    ppn_t tresp_ppn_i;
    logic ifill_req_valid_o, ifill_resp_valid_i;
    paddr_t ifill_req_paddr_o;
    line_t ifill_resp_data_i;

    int unsigned cyc = 0, errors = 0, err_base = 0, fills = 0, fill_base = 0;
    int unsigned ntests = 0, nfail = 0, miss_left = 0, treq_cnt = 0, rr_m = 0;
    vpn_t   miss_vpn = '0;
    string  test_name = "reset";
    paddr_t fill_exp_q[$];
    fetch_t exp_data_q[$];
    vaddr_t exp_vaddr_q[$];
    bit     exp_xcpt_q[$];
    int unsigned exp_cyc_q[$];   // 0 when the latency may vary
    ppn_t   tag_m [`ICACHE_SETS][`ICACHE_WAYS];
    bit [`ICACHE_WAYS-1:0] val_m [`ICACHE_SETS];

    icache_top dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) begin
            $display("timeout after %0d cycles in test %s", cyc, test_name);
            $display("Verification failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // memory pattern, reference and cache model
    // ------------------------------------------------------------
    function automatic logic [31:0] mem_word(paddr_t pa);
        return {pa[39:32] ^ pa[9:2], pa[31:8]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic line_t line_pattern(paddr_t pa);
        line_t l;
        for (int i = 0; i < 16; i++) l[i*32 +: 32] = mem_word({pa[39:6], 4'(i), 2'b00});
        return l;
    endfunction

    function automatic fetch_t ref_block(paddr_t pa);
        fetch_t b;
        for (int k = 0; k < 4; k++) b[k*32 +: 32] = mem_word({pa[39:4], 2'(k), 2'b00});
        return b;
    endfunction

    // returns 1 on a hit and allocates a way on a miss
    function automatic bit model_access(set_t s, ppn_t t);
        int v;
        v = -1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (val_m[s][w] && tag_m[s][w] == t) return 1'b1;
        end
        for (int w = `ICACHE_WAYS - 1; w >= 0; w--) if (!val_m[s][w]) v = w;
        if (v < 0) begin
            v = rr_m;  // set is full
            rr_m = (rr_m + 1) % `ICACHE_WAYS;
        end
        val_m[s][v] = 1'b1;
        tag_m[s][v] = t;
        return 1'b0;
    endfunction

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    task automatic report(string msg);
        errors++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    task automatic check_fetch(string what, fetch_t exp, fetch_t act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_paddr(string what, paddr_t exp, paddr_t act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_vaddr(string what, vaddr_t exp, vaddr_t act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(string what, int unsigned exp, int unsigned act);
        if (exp != act) begin
            errors++;
            $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    // mmu model answers in the cycle of the request
    assign tresp_ppn_i  = ppn_t'(treq_vpn_o) + PPN_OFS;
    assign tresp_xcpt_i = treq_valid_o && (treq_vpn_o == XCPT_VPN);
    assign tresp_miss_i = treq_valid_o && (treq_vpn_o == miss_vpn) && (miss_left != 0);

    always @(posedge clk_i) if (tresp_miss_i) miss_left <= miss_left - 1;
    always @(posedge clk_i) if (treq_valid_o && treq_vpn_o == miss_vpn) treq_cnt++;

    initial begin : fill_model
        paddr_t pa;
        int unsigned delay;
        void'($urandom(32'h96e1));
        ifill_resp_valid_i = 1'b0;
        ifill_resp_data_i  = '0;
        forever begin
            @(negedge clk_i);
            if (ifill_req_valid_o) begin
                pa = ifill_req_paddr_o;
                fills++;
                if (fill_exp_q.size() == 0) report("fill request that the model did not predict");
                else check_paddr("fill paddr", fill_exp_q.pop_front(), pa);
                delay = 2 + $urandom % 5;
                repeat (delay - 1) @(negedge clk_i);
                ifill_resp_valid_i = 1'b1;
                ifill_resp_data_i  = line_pattern(pa);
                @(negedge clk_i);
                ifill_resp_valid_i = 1'b0;
            end
        end
    end

    always @(negedge clk_i) begin : compare
        fetch_t d;
        int unsigned c;
        bit x;
        if (rstn_i && resp_valid_o) begin
            if (exp_vaddr_q.size() == 0) begin
                report("response with no request outstanding");
            end else begin
                d = exp_data_q.pop_front();
                x = exp_xcpt_q.pop_front();
                c = exp_cyc_q.pop_front();
                check_vaddr("resp vaddr", exp_vaddr_q.pop_front(), resp_vaddr_o);
                check_flag("resp xcpt", x, resp_xcpt_o);
                if (!x) check_fetch("resp data", d, resp_data_o);
                if (c != 0) check_count("answer cycle", c, cyc);
            end
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic fetch(vpn_t vpn, idx_t idx);
        paddr_t pa;
        bit hit, xcpt, slow;
        pa   = {ppn_t'(vpn) + PPN_OFS, idx[9:0]};
        xcpt = (vpn == XCPT_VPN);
        @(negedge clk_i);
        ireq_valid_i = 1'b1;
        ireq_idx_i   = idx;
        ireq_vpn_i   = vpn;
        do @(posedge clk_i); while (!resp_ready_o);
        slow = (vpn == miss_vpn) && (miss_left != 0);
        hit  = xcpt || model_access(pa[9:6], pa[39:10]);
        if (!hit) fill_exp_q.push_back({pa[39:6], 6'b0});
        exp_data_q.push_back(ref_block(pa));
        exp_vaddr_q.push_back({vpn, idx});
        exp_xcpt_q.push_back(xcpt);
        exp_cyc_q.push_back((hit && !slow) ? cyc + 1 : 0);
    endtask

    task automatic wait_responses();
        @(negedge clk_i) ireq_valid_i = 1'b0;
        while (exp_vaddr_q.size() != 0) @(negedge clk_i);
        @(negedge clk_i);
    endtask

    task automatic end_test(int unsigned exp_fills);
        wait_responses();
        check_count("fill requests", exp_fills, fills - fill_base);
        ntests++;
        if (errors != err_base) nfail++;
        $display("%s %s", (errors == err_base) ? "PASS" : "FAIL", test_name);
        err_base  = errors;
        fill_base = fills;
    endtask

    task automatic do_flush();
        @(negedge clk_i) flush_i = 1'b1;
        do @(posedge clk_i); while (!resp_ready_o);
        @(negedge clk_i) flush_i = 1'b0;
        val_m = '{default: '0};
        rr_m  = 0;
    endtask

    initial begin
        rstn_i = 1'b0;
        flush_i = 1'b0;
        ireq_valid_i = 1'b0;
        ireq_idx_i = '0;
        ireq_vpn_i = '0;
        val_m = '{default: '0};
        repeat (5) @(posedge clk_i);
        @(negedge clk_i) rstn_i = 1'b1;

        test_name = "cold_miss";
        fetch(28'h100, 12'h040);
        end_test(1);

        test_name = "hit";
        fetch(28'h100, 12'h040);  // back to back from here
        fetch(28'h100, 12'h050);
        fetch(28'h100, 12'h060);
        fetch(28'h100, 12'h070);
        end_test(0);

        test_name = "eviction";
        for (int i = 0; i < 5; i++) fetch(28'h200 + i, 12'h0c0);
        fetch(28'h201, 12'h0c0);
        fetch(28'h200, 12'h0c0);
        fetch(28'h204, 12'h0c0);  // pointer has moved past way 0
        end_test(6);

        test_name = "flush";
        do_flush();
        fetch(28'h100, 12'h040);
        fetch(28'h204, 12'h0c0);
        fetch(28'h200, 12'h0d0);
        fetch(28'h100, 12'h070);
        end_test(3);

        test_name = "mmu_miss";
        miss_vpn = 28'h300;
        miss_left = 3;
        treq_cnt = 0;
        fetch(28'h300, 12'h100);
        wait_responses();
        check_count("translation cycles", 4, treq_cnt);
        end_test(1);

        test_name = "exception";
        fetch(XCPT_VPN, 12'h080);
        end_test(0);

        $display("%0d tests, %0d failed, %0d errors", ntests, nfail, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: icache.f
+incdir+src
src/icache_pkg.sv
src/icache_way_ram.sv
src/icache_req_stage.sv
src/icache_lookup.sv
src/icache_hit_check.sv
src/icache_ctrl.sv
src/icache_top.sv
sim/icache_properties.sv
sim/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - src
    files:
      - src/icache_pkg.sv
      - src/icache_way_ram.sv
      - src/icache_req_stage.sv
      - src/icache_lookup.sv
      - src/icache_hit_check.sv
      - src/icache_ctrl.sv
      - src/icache_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/icache_properties.sv
      - sim/icache_tb.sv
